// File: dma_ctrl_pkg.sv
// DMA control port package with widths, register offsets, request kinds and command word views
package dma_ctrl_pkg;

   // ******************************
   // Widths and offsets
   // ******************************
   localparam int CTRL_DATA_WIDTH  = 32;    // One target word
   localparam int CMD_LEN_WIDTH    = 16;
   localparam int CMD_OPC_WIDTH    = 1;
   localparam int ALLOC_STATUS_LSB = 16;    // Allocation status field in status word

   localparam logic [1:0] OFFSET_CMD    = 2'd0;   // Address bits 3 to 2
   localparam logic [1:0] OFFSET_STATUS = 2'd1;

   // Decoded target request
   typedef enum logic [2:0] {
      OP_NONE,
      OP_SID_READ,
      OP_CMD_WRITE,
      OP_STATUS_READ,
      OP_CLEAR_WRITE,
      OP_INVALID
   } ctrl_op_e;

   // Command beat layout, MSB first
   typedef struct packed {
      logic [8:0]               rsvd;
      logic                     twd_tcdm;   // Reserved, 2D not supported
      logic                     ble;        // Broadcast lines enable
      logic                     ile;        // Interrupt lines enable
      logic                     ele;        // Event lines enable
      logic                     twd_ext;    // Reserved, 2D not supported
      logic                     inc;        // Incremental transfer
      logic [CMD_OPC_WIDTH-1:0] opc;
      logic [CMD_LEN_WIDTH-1:0] len;        // Length in bytes
   } cmd_fields_t;

   // First beat is a command, the next two are plain addresses
   typedef union packed {
      cmd_fields_t                cmd;
      logic [CTRL_DATA_WIDTH-1:0] raw;
   } cmd_word_u;

   // What the response cycle returns
   typedef enum logic [1:0] {
      RESP_ACK,
      RESP_SID,
      RESP_STATUS
   } resp_kind_e;

endpackage

// File: ctrl_op_if.sv
// Decoded target request passed from the decode stage to the sequencer
`timescale 1ns/100ps

interface ctrl_op_if #(
   parameter int PE_ID_WIDTH = 1
)
(
   input logic clk_i,
   input logic rst_ni
);
   import dma_ctrl_pkg::*;

   ctrl_op_e               op;     // OP_NONE when no request
   cmd_word_u              data;   // Write data word
   logic [PE_ID_WIDTH-1:0] id;     // Requesting PE
   logic                   gnt;    // Request accepted this cycle

   modport decode (input clk_i, input rst_ni, input gnt, output op, output data, output id);
   modport seq    (input op, input data, output gnt);

endinterface

// File: ctrl_resp_if.sv
// Granted beat passed from the sequencer to the response stage
`timescale 1ns/100ps

interface ctrl_resp_if #(
   parameter int  NB_TRANSFERS = 4,
   localparam int SID_WIDTH    = (NB_TRANSFERS == 1) ? 1 : $clog2(NB_TRANSFERS)
);
   import dma_ctrl_pkg::*;

   logic                 fire;   // One pulse per granted request
   resp_kind_e           kind;
   logic [SID_WIDTH-1:0] sid;    // Id offered by the allocator

   modport seq  (output fire, output kind, output sid);
   modport resp (input fire, input kind, input sid);

endinterface

// File: ctrl_decode.sv
// Decode stage that classifies each target request by register offset and direction
`timescale 1ns/100ps

module ctrl_decode #(
   parameter int PE_ID_WIDTH = 1
)
(
   input  logic                                    req_i,
   input  logic                                    we_i,
   input  logic [dma_ctrl_pkg::CTRL_DATA_WIDTH-1:0] addr_i,
   input  logic [dma_ctrl_pkg::CTRL_DATA_WIDTH-1:0] data_i,
   input  logic [PE_ID_WIDTH-1:0]                  id_i,
   ctrl_op_if.decode                               op_o
);
   import dma_ctrl_pkg::*;

   logic [1:0] offset;

   assign offset = addr_i[3:2];   // Word offset, byte lanes ignored

   // ******************************
   // Request classification
   // ******************************
   always_comb
   begin
      op_o.op = OP_NONE;
      if (req_i)
      begin
         case (offset)
            OFFSET_CMD:    op_o.op = we_i ? OP_CMD_WRITE : OP_SID_READ;
            OFFSET_STATUS: op_o.op = we_i ? OP_CLEAR_WRITE : OP_STATUS_READ;
            default:       op_o.op = OP_INVALID;
         endcase
      end
   end

   assign op_o.data.raw = data_i;   // Meaning depends on the beat
   assign op_o.id       = id_i;

   // Unknown offsets must stall the target and never be accepted
   a_no_invalid_gnt : assert property (
      @(posedge op_o.clk_i) disable iff (!op_o.rst_ni)
      op_o.gnt |-> (op_o.op != OP_INVALID)
   );

endmodule

// File: cmd_sequencer.sv
// Control sequencer that walks the command beats, holds the SID and waits for the transfer
`timescale 1ns/100ps

module cmd_sequencer #(
   parameter int  NB_TRANSFERS   = 4,
   parameter int  TCDM_ADD_WIDTH = 12,
   parameter int  EXT_ADD_WIDTH  = 29,
   localparam int SID_WIDTH      = (NB_TRANSFERS == 1) ? 1 : $clog2(NB_TRANSFERS)
)
(
   input  logic                                  clk_i,
   input  logic                                  rst_ni,
   ctrl_op_if.seq                                op_i,
   ctrl_resp_if.seq                              resp_o,
   // Command queue
   input  logic                                  cmd_gnt_i,
   output logic                                  cmd_req_o,
   output logic [dma_ctrl_pkg::CMD_LEN_WIDTH-1:0] cmd_len_o,
   output logic [dma_ctrl_pkg::CMD_OPC_WIDTH-1:0] cmd_opc_o,
   output logic                                  cmd_inc_o,
   output logic                                  cmd_ele_o,
   output logic                                  cmd_ile_o,
   output logic                                  cmd_ble_o,
   output logic [SID_WIDTH-1:0]                  cmd_sid_o,
   // Address queues
   input  logic                                  tcdm_gnt_i,
   output logic                                  tcdm_req_o,
   output logic [TCDM_ADD_WIDTH-1:0]             tcdm_add_o,
   input  logic                                  ext_gnt_i,
   output logic                                  ext_req_o,
   output logic [EXT_ADD_WIDTH-1:0]              ext_add_o,
   // SID allocator
   output logic                                  trans_alloc_req_o,
   input  logic                                  trans_alloc_gnt_i,
   input  logic [SID_WIDTH-1:0]                  trans_alloc_ret_i,
   output logic [NB_TRANSFERS-1:0]               trans_alloc_clr_o,
   // Arbiter observation and transfer status
   input  logic                                  arb_req_i,
   input  logic                                  arb_gnt_i,
   input  logic [SID_WIDTH-1:0]                  arb_sid_i,
   input  logic [NB_TRANSFERS-1:0]               trans_status_i,
   output logic                                  busy_o
);
   import dma_ctrl_pkg::*;

   localparam logic [2:0] S_IDLE    = 3'd0;
   localparam logic [2:0] S_TCDM    = 3'd1;   // Waiting for local address beat
   localparam logic [2:0] S_EXT     = 3'd2;   // Waiting for external address beat
   localparam logic [2:0] S_BARRIER = 3'd3;   // Command not yet taken by arbiter
   localparam logic [2:0] S_DONE    = 3'd4;

   logic [2:0]           state_q;
   logic [2:0]           state_d;
   logic [SID_WIDTH-1:0] sid_q;
   logic                 barrier_q;
   logic                 beat_gnt;
   logic                 arb_hit;

   assign beat_gnt = (state_q == S_TCDM) ? tcdm_gnt_i : ext_gnt_i;
   assign arb_hit  = arb_req_i && arb_gnt_i && (arb_sid_i == sid_q);

   // ******************************
   // Control FSM
   // ******************************
   always_comb
   begin
      state_d           = state_q;
      op_i.gnt          = 1'b0;
      cmd_req_o         = 1'b0;
      tcdm_req_o        = 1'b0;
      ext_req_o         = 1'b0;
      trans_alloc_req_o = 1'b0;
      trans_alloc_clr_o = '0;
      resp_o.kind       = RESP_ACK;
      busy_o            = 1'b1;

      case (state_q)
         S_IDLE:
         begin
            busy_o = (op_i.op != OP_NONE);
            case (op_i.op)
               OP_SID_READ:
               begin
                  trans_alloc_req_o = 1'b1;
                  op_i.gnt          = trans_alloc_gnt_i;   // Stall until an id is free
                  resp_o.kind       = RESP_SID;
               end
               OP_CMD_WRITE:
               begin
                  cmd_req_o = 1'b1;
                  op_i.gnt  = cmd_gnt_i;
                  if (cmd_gnt_i)
                     state_d = S_TCDM;
               end
               OP_STATUS_READ:
               begin
                  op_i.gnt    = 1'b1;
                  resp_o.kind = RESP_STATUS;
               end
               OP_CLEAR_WRITE:
               begin
                  op_i.gnt          = 1'b1;
                  trans_alloc_clr_o = op_i.data.raw[NB_TRANSFERS-1:0];
               end
               default:
                  state_d = S_IDLE;   // Invalid offsets are never granted
            endcase
         end

         S_TCDM, S_EXT:
         begin
            if (op_i.op == OP_CMD_WRITE)
            begin
               tcdm_req_o = (state_q == S_TCDM);
               ext_req_o  = (state_q == S_EXT);
               op_i.gnt   = beat_gnt;
               if (beat_gnt)
                  state_d = (state_q == S_TCDM) ? S_EXT : S_BARRIER;
            end
            else if (op_i.op != OP_NONE)
               state_d = S_IDLE;   // Wrong kind aborts the sequence
         end

         S_BARRIER:
            if (!barrier_q)
               state_d = S_DONE;

         S_DONE:
            if (trans_status_i[sid_q])
               state_d = S_IDLE;

         default:
            state_d = S_IDLE;
      endcase
   end

   // ******************************
   // State, SID and barrier
   // ******************************
   always_ff @(posedge clk_i, negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         state_q   <= S_IDLE;
         sid_q     <= '0;
         barrier_q <= 1'b0;
      end
      else
      begin
         state_q <= state_d;
         if (trans_alloc_req_o && trans_alloc_gnt_i)
            sid_q <= trans_alloc_ret_i;
         if (cmd_req_o && cmd_gnt_i)
            barrier_q <= 1'b1;   // Armed when the command is queued
         else if (arb_hit)
            barrier_q <= 1'b0;
      end
   end

   assign resp_o.fire = op_i.gnt;
   assign resp_o.sid  = trans_alloc_ret_i;   // Id returned by a SID read

   // Queue payloads straight from the presented word
   assign cmd_len_o  = op_i.data.cmd.len - CMD_LEN_WIDTH'(1);
   assign cmd_opc_o  = op_i.data.cmd.opc;
   assign cmd_inc_o  = op_i.data.cmd.inc;
   assign cmd_ele_o  = op_i.data.cmd.ele;
   assign cmd_ile_o  = op_i.data.cmd.ile;
   assign cmd_ble_o  = op_i.data.cmd.ble;
   assign cmd_sid_o  = sid_q;
   assign tcdm_add_o = op_i.data.raw[TCDM_ADD_WIDTH-1:0];
   assign ext_add_o  = op_i.data.raw[EXT_ADD_WIDTH-1:0];

   // Decode must present a request before any beat is accepted
   a_gnt_needs_req : assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      op_i.gnt |-> (op_i.op != OP_NONE)
   );

   a_one_queue_req : assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      $onehot0({cmd_req_o, tcdm_req_o, ext_req_o, trans_alloc_req_o})
   );

endmodule

// File: ctrl_response.sv
// Response stage that returns valid, data and PE id one cycle after each grant
`timescale 1ns/100ps

module ctrl_response #(
   parameter int  NB_TRANSFERS = 4,
   parameter int  PE_ID_WIDTH  = 1,
   localparam int SID_WIDTH    = (NB_TRANSFERS == 1) ? 1 : $clog2(NB_TRANSFERS)
)
(
   input  logic                                    clk_i,
   input  logic                                    rst_ni,
   ctrl_resp_if.resp                               resp_i,
   input  logic [PE_ID_WIDTH-1:0]                  id_i,
   input  logic [NB_TRANSFERS-1:0]                 trans_status_i,
   input  logic [NB_TRANSFERS-1:0]                 trans_alloc_status_i,
   output logic                                    r_valid_o,
   output logic [dma_ctrl_pkg::CTRL_DATA_WIDTH-1:0] r_data_o,
   output logic [PE_ID_WIDTH-1:0]                  r_id_o
);
   import dma_ctrl_pkg::*;

   logic                   valid_q;
   resp_kind_e             kind_q;
   logic [SID_WIDTH-1:0]   sid_q;
   logic [PE_ID_WIDTH-1:0] id_q;

   always_ff @(posedge clk_i, negedge rst_ni)
   begin
      if (!rst_ni)
         valid_q <= 1'b0;
      else
         valid_q <= resp_i.fire;
   end

   // Captured with the grant
   always_ff @(posedge clk_i)
   begin
      if (resp_i.fire)
      begin
         kind_q <= resp_i.kind;
         sid_q  <= resp_i.sid;
         id_q   <= id_i;
      end
   end

   // ******************************
   // Response word
   // ******************************
   always_comb
   begin
      r_data_o = '0;
      if (valid_q)
      begin
         case (kind_q)
            RESP_SID:
               r_data_o[SID_WIDTH-1:0] = sid_q;
            RESP_STATUS:
            begin
               // Status is sampled in the response cycle itself
               r_data_o[NB_TRANSFERS-1:0]                  = trans_status_i;
               r_data_o[ALLOC_STATUS_LSB +: NB_TRANSFERS] = trans_alloc_status_i;
            end
            default:
               r_data_o = '0;   // Plain write acknowledge
         endcase
      end
   end

   assign r_valid_o = valid_q;
   assign r_id_o    = id_q;   // Echoed PE id

endmodule

// File: dma_ctrl_top.sv
// DMA control port front end built from decode, sequence and response stages
`timescale 1ns/100ps

module dma_ctrl_top #(
   parameter int  NB_TRANSFERS   = 4,
   parameter int  TCDM_ADD_WIDTH = 12,
   parameter int  EXT_ADD_WIDTH  = 29,
   parameter int  PE_ID_WIDTH    = 1,
   localparam int SID_WIDTH      = (NB_TRANSFERS == 1) ? 1 : $clog2(NB_TRANSFERS)
)
(
   input  logic                                    clk_i,
   input  logic                                    rst_ni,
   // Target port
   input  logic                                    ctrl_targ_req_i,
   input  logic                                    ctrl_targ_type_i,   // 1 is a read
   input  logic [dma_ctrl_pkg::CTRL_DATA_WIDTH-1:0] ctrl_targ_add_i,
   input  logic [dma_ctrl_pkg::CTRL_DATA_WIDTH-1:0] ctrl_targ_data_i,
   input  logic [PE_ID_WIDTH-1:0]                  ctrl_targ_id_i,
   output logic                                    ctrl_targ_gnt_o,
   output logic                                    ctrl_targ_r_valid_o,
   output logic [dma_ctrl_pkg::CTRL_DATA_WIDTH-1:0] ctrl_targ_r_data_o,
   output logic [PE_ID_WIDTH-1:0]                  ctrl_targ_r_id_o,
   // Command queue
   input  logic                                    cmd_gnt_i,
   output logic                                    cmd_req_o,
   output logic [dma_ctrl_pkg::CMD_LEN_WIDTH-1:0]   cmd_len_o,
   output logic [dma_ctrl_pkg::CMD_OPC_WIDTH-1:0]   cmd_opc_o,
   output logic                                    cmd_inc_o,
   output logic                                    cmd_ele_o,
   output logic                                    cmd_ile_o,
   output logic                                    cmd_ble_o,
   output logic [SID_WIDTH-1:0]                    cmd_sid_o,
   // TCDM and external address queues
   input  logic                                    tcdm_gnt_i,
   output logic                                    tcdm_req_o,
   output logic [TCDM_ADD_WIDTH-1:0]               tcdm_add_o,
   input  logic                                    ext_gnt_i,
   output logic                                    ext_req_o,
   output logic [EXT_ADD_WIDTH-1:0]                ext_add_o,
   // SID allocator
   output logic                                    trans_alloc_req_o,
   input  logic                                    trans_alloc_gnt_i,
   input  logic [SID_WIDTH-1:0]                    trans_alloc_ret_i,
   output logic [NB_TRANSFERS-1:0]                 trans_alloc_clr_o,
   input  logic [NB_TRANSFERS-1:0]                 trans_alloc_status_i,
   // Arbiter observation and status
   input  logic                                    arb_req_i,
   input  logic                                    arb_gnt_i,
   input  logic [SID_WIDTH-1:0]                    arb_sid_i,
   input  logic [NB_TRANSFERS-1:0]                 trans_status_i,
   output logic                                    busy_o
);

   ctrl_op_if #(.PE_ID_WIDTH(PE_ID_WIDTH)) op_if (
      .clk_i  (clk_i),
      .rst_ni (rst_ni)
   );

   ctrl_resp_if #(.NB_TRANSFERS(NB_TRANSFERS)) resp_if ();

   // ******************************
   // Decode
   // ******************************
   ctrl_decode #(
      .PE_ID_WIDTH (PE_ID_WIDTH)
   ) ctrl_decode_inst (
      .req_i  (ctrl_targ_req_i),
      .we_i   (!ctrl_targ_type_i),
      .addr_i (ctrl_targ_add_i),
      .data_i (ctrl_targ_data_i),
      .id_i   (ctrl_targ_id_i),
      .op_o   (op_if)
   );

   // ******************************
   // Sequence
   // ******************************
   cmd_sequencer #(
      .NB_TRANSFERS   (NB_TRANSFERS),
      .TCDM_ADD_WIDTH (TCDM_ADD_WIDTH),
      .EXT_ADD_WIDTH  (EXT_ADD_WIDTH)
   ) cmd_sequencer_inst (
      .clk_i             (clk_i),
      .rst_ni            (rst_ni),
      .op_i              (op_if),
      .resp_o            (resp_if),
      .cmd_gnt_i         (cmd_gnt_i),
      .cmd_req_o         (cmd_req_o),
      .cmd_len_o         (cmd_len_o),
      .cmd_opc_o         (cmd_opc_o),
      .cmd_inc_o         (cmd_inc_o),
      .cmd_ele_o         (cmd_ele_o),
      .cmd_ile_o         (cmd_ile_o),
      .cmd_ble_o         (cmd_ble_o),
      .cmd_sid_o         (cmd_sid_o),
      .tcdm_gnt_i        (tcdm_gnt_i),
      .tcdm_req_o        (tcdm_req_o),
      .tcdm_add_o        (tcdm_add_o),
      .ext_gnt_i         (ext_gnt_i),
      .ext_req_o         (ext_req_o),
      .ext_add_o         (ext_add_o),
      .trans_alloc_req_o (trans_alloc_req_o),
      .trans_alloc_gnt_i (trans_alloc_gnt_i),
      .trans_alloc_ret_i (trans_alloc_ret_i),
      .trans_alloc_clr_o (trans_alloc_clr_o),
      .arb_req_i         (arb_req_i),
      .arb_gnt_i         (arb_gnt_i),
      .arb_sid_i         (arb_sid_i),
      .trans_status_i    (trans_status_i),
      .busy_o            (busy_o)
   );

   assign ctrl_targ_gnt_o = op_if.gnt;   // Same-cycle target grant

   // ******************************
   // Respond
   // ******************************
   ctrl_response #(
      .NB_TRANSFERS (NB_TRANSFERS),
      .PE_ID_WIDTH  (PE_ID_WIDTH)
   ) ctrl_response_inst (
      .clk_i                (clk_i),
      .rst_ni               (rst_ni),
      .resp_i               (resp_if),
      .id_i                 (op_if.id),
      .trans_status_i       (trans_status_i),
      .trans_alloc_status_i (trans_alloc_status_i),
      .r_valid_o            (ctrl_targ_r_valid_o),
      .r_data_o             (ctrl_targ_r_data_o),
      .r_id_o               (ctrl_targ_r_id_o)
   );

endmodule

// File: tb_dma_ctrl_model.svh
// Cycle model of the DMA control port and typed compare tasks for the testbench
`ifndef TB_DMA_CTRL_MODEL_SVH
`define TB_DMA_CTRL_MODEL_SVH

localparam int K_NONE = 0;   // Request kinds seen on the target port
localparam int K_SID  = 1;
localparam int K_CMD  = 2;
localparam int K_STAT = 3;
localparam int K_CLR  = 4;
localparam int K_BAD  = 5;

localparam int M_IDLE = 0;   // Engine phases
localparam int M_TCDM = 1;
localparam int M_EXT  = 2;
localparam int M_BAR  = 3;
localparam int M_DONE = 4;

localparam int R_ACK  = 0;
localparam int R_SID  = 1;
localparam int R_STAT = 2;

int                     m_state      = M_IDLE;
logic [SID_WIDTH-1:0]   m_sid        = '0;
logic                   m_barrier    = 1'b0;   // Command not yet taken by the arbiter
logic                   m_resp_valid = 1'b0;
int                     m_resp_kind  = R_ACK;
logic [SID_WIDTH-1:0]   m_resp_sid   = '0;
logic [PE_ID_WIDTH-1:0] m_resp_id    = '0;

// ******************************
// Compare tasks
// ******************************
task automatic check_bit(input string name, input logic got, input logic exp);
   if (got !== exp)
      stop_with_failure($sformatf("error %s: got 0x%h expected 0x%h", name, got, exp));
endtask

task automatic check_sid(input string name, input logic [SID_WIDTH-1:0] got,
                         input logic [SID_WIDTH-1:0] exp);
   if (got !== exp)
      stop_with_failure($sformatf("error %s: got 0x%h expected 0x%h", name, got, exp));
endtask

task automatic check_mask(input string name, input logic [NB_TRANSFERS-1:0] got,
                          input logic [NB_TRANSFERS-1:0] exp);
   if (got !== exp)
      stop_with_failure($sformatf("error %s: got 0x%h expected 0x%h", name, got, exp));
endtask

task automatic check_word(input string name, input logic [CTRL_DATA_WIDTH-1:0] got,
                          input logic [CTRL_DATA_WIDTH-1:0] exp);
   if (got !== exp)
      stop_with_failure($sformatf("error %s: got 0x%h expected 0x%h", name, got, exp));
endtask

task automatic check_cmd(input string name, input cmd_fields_t got, input cmd_fields_t exp);
   if (got !== exp)
      stop_with_failure($sformatf("error %s: got 0x%h expected 0x%h", name, got, exp));
endtask

// Offset in address bits 3 to 2, type high for a read
function automatic int req_kind();
   if (!ctrl_targ_req_i)
      return K_NONE;
   if (ctrl_targ_add_i[3:2] == 2'd0)
      return ctrl_targ_type_i ? K_SID : K_CMD;
   if (ctrl_targ_add_i[3:2] == 2'd1)
      return ctrl_targ_type_i ? K_STAT : K_CLR;
   return K_BAD;
endfunction

// ******************************
// Per-cycle prediction
// ******************************
task automatic model_cycle();
   int                      kind;
   int                      nxt;
   logic                    e_gnt;
   logic                    e_cmd;
   logic                    e_tcdm;
   logic                    e_ext;
   logic                    e_alloc;
   logic                    e_busy;
   logic                    hit;
   logic [NB_TRANSFERS-1:0] e_clr;
   logic [31:0]             e_data;
   cmd_fields_t             e_fields;
   cmd_fields_t             g_fields;

   kind    = req_kind();
   nxt     = m_state;
   e_gnt   = 1'b0;
   e_cmd   = 1'b0;
   e_tcdm  = 1'b0;
   e_ext   = 1'b0;
   e_alloc = 1'b0;
   e_busy  = 1'b1;
   e_clr   = '0;
   case (m_state)
      M_IDLE:
      begin
         e_busy = (kind != K_NONE);   // Idle engine only busy while asked
         if (kind == K_SID)
         begin
            e_alloc = 1'b1;
            e_gnt   = trans_alloc_gnt_i;
         end
         else if (kind == K_CMD)
         begin
            e_cmd = 1'b1;
            e_gnt = cmd_gnt_i;
            nxt   = cmd_gnt_i ? M_TCDM : M_IDLE;
         end
         else if (kind == K_STAT || kind == K_CLR)
            e_gnt = 1'b1;
         if (kind == K_CLR)
            e_clr = ctrl_targ_data_i[NB_TRANSFERS-1:0];
      end
      M_TCDM, M_EXT:
      begin
         if (kind == K_CMD)
         begin
            e_tcdm = (m_state == M_TCDM);
            e_ext  = (m_state == M_EXT);
            e_gnt  = e_tcdm ? tcdm_gnt_i : ext_gnt_i;
            if (e_gnt)
               nxt = e_tcdm ? M_EXT : M_BAR;
         end
         else if (kind != K_NONE)
            nxt = M_IDLE;   // Wrong kind drops the sequence
      end
      M_BAR:
         if (!m_barrier)
            nxt = M_DONE;
      default:
         if (trans_status_i[m_sid])
            nxt = M_IDLE;
   endcase

   check_bit("ctrl_targ_gnt_o", ctrl_targ_gnt_o, e_gnt);
   check_bit("cmd_req_o", cmd_req_o, e_cmd);
   check_bit("tcdm_req_o", tcdm_req_o, e_tcdm);
   check_bit("ext_req_o", ext_req_o, e_ext);
   check_bit("trans_alloc_req_o", trans_alloc_req_o, e_alloc);
   check_mask("trans_alloc_clr_o", trans_alloc_clr_o, e_clr);
   check_bit("busy_o", busy_o, e_busy);
   if (e_cmd)
   begin
      e_fields     = '0;
      e_fields.len = ctrl_targ_data_i[15:0] - 16'd1;
      e_fields.opc = ctrl_targ_data_i[16];
      e_fields.inc = ctrl_targ_data_i[17];
      e_fields.ele = ctrl_targ_data_i[19];
      e_fields.ile = ctrl_targ_data_i[20];
      e_fields.ble = ctrl_targ_data_i[21];
      g_fields     = '0;
      g_fields.len = cmd_len_o;
      g_fields.opc = cmd_opc_o;
      g_fields.inc = cmd_inc_o;
      g_fields.ele = cmd_ele_o;
      g_fields.ile = cmd_ile_o;
      g_fields.ble = cmd_ble_o;
      check_cmd("cmd fields", g_fields, e_fields);
      check_sid("cmd_sid_o", cmd_sid_o, m_sid);
   end
   if (e_tcdm)
      check_word("tcdm_add_o", 32'(tcdm_add_o), 32'(ctrl_targ_data_i[TCDM_ADD_WIDTH-1:0]));
   if (e_ext)
      check_word("ext_add_o", 32'(ext_add_o), 32'(ctrl_targ_data_i[EXT_ADD_WIDTH-1:0]));

   check_bit("ctrl_targ_r_valid_o", ctrl_targ_r_valid_o, m_resp_valid);
   if (m_resp_valid)
   begin
      case (m_resp_kind)
         R_SID:   e_data = 32'(m_resp_sid);
         R_STAT:  e_data = (32'(trans_alloc_status_i) << 16) | 32'(trans_status_i);
         default: e_data = '0;
      endcase
      check_word("ctrl_targ_r_data_o", ctrl_targ_r_data_o, e_data);
      check_word("ctrl_targ_r_id_o", 32'(ctrl_targ_r_id_o), 32'(m_resp_id));
   end

   hit = arb_req_i && arb_gnt_i && (arb_sid_i == m_sid);
   if (!rst_ni)
   begin
      m_state      = M_IDLE;
      m_sid        = '0;
      m_barrier    = 1'b0;
      m_resp_valid = 1'b0;
   end
   else
   begin
      m_resp_valid = e_gnt;
      if (e_gnt)
      begin
         m_resp_kind = (kind == K_SID) ? R_SID : ((kind == K_STAT) ? R_STAT : R_ACK);
         m_resp_sid  = trans_alloc_ret_i;   // Id offered in the grant cycle
         m_resp_id   = ctrl_targ_id_i;
      end
      if (e_alloc && trans_alloc_gnt_i)
         m_sid = trans_alloc_ret_i;
      if (e_cmd && cmd_gnt_i)
         m_barrier = 1'b1;
      else if (hit)
         m_barrier = 1'b0;
      m_state = nxt;
   end
endtask

`endif

// File: tb_dma_ctrl.sv
// Testbench for the DMA control port with random back-pressure and a cycle model
`timescale 1ns/100ps

module tb_dma_ctrl;
   import dma_ctrl_pkg::*;

   localparam int NB_TRANSFERS   = 4;
   localparam int TCDM_ADD_WIDTH = 12;
   localparam int EXT_ADD_WIDTH  = 29;
   localparam int PE_ID_WIDTH    = 1;
   localparam int SID_WIDTH      = (NB_TRANSFERS == 1) ? 1 : $clog2(NB_TRANSFERS);
   localparam int SEED           = 77521;
   localparam int N_ROUNDS       = 8;
   localparam int N_OPS          = N_ROUNDS * 8;   // Target accesses per round

   logic                       clk_i                = 1'b0;
   logic                       rst_ni               = 1'b0;
   logic                       ctrl_targ_req_i      = 1'b0;
   logic                       ctrl_targ_type_i     = 1'b0;
   logic [CTRL_DATA_WIDTH-1:0] ctrl_targ_add_i      = '0;
   logic [CTRL_DATA_WIDTH-1:0] ctrl_targ_data_i     = '0;
   logic [PE_ID_WIDTH-1:0]     ctrl_targ_id_i       = '0;
   logic                       cmd_gnt_i            = 1'b0;
   logic                       tcdm_gnt_i           = 1'b0;
   logic                       ext_gnt_i            = 1'b0;
   logic                       trans_alloc_gnt_i    = 1'b0;
   logic [SID_WIDTH-1:0]       trans_alloc_ret_i    = '0;
   logic [NB_TRANSFERS-1:0]    trans_alloc_status_i = '0;
   logic                       arb_req_i            = 1'b0;
   logic                       arb_gnt_i            = 1'b0;
   logic [SID_WIDTH-1:0]       arb_sid_i            = '0;
   logic [NB_TRANSFERS-1:0]    trans_status_i       = '0;

   logic                       ctrl_targ_gnt_o;
   logic                       ctrl_targ_r_valid_o;
   logic [CTRL_DATA_WIDTH-1:0] ctrl_targ_r_data_o;
   logic [PE_ID_WIDTH-1:0]     ctrl_targ_r_id_o;
   logic                       cmd_req_o;
   logic [CMD_LEN_WIDTH-1:0]   cmd_len_o;
   logic [CMD_OPC_WIDTH-1:0]   cmd_opc_o;
   logic                       cmd_inc_o;
   logic                       cmd_ele_o;
   logic                       cmd_ile_o;
   logic                       cmd_ble_o;
   logic [SID_WIDTH-1:0]       cmd_sid_o;
   logic                       tcdm_req_o;
   logic [TCDM_ADD_WIDTH-1:0]  tcdm_add_o;
   logic                       ext_req_o;
   logic [EXT_ADD_WIDTH-1:0]   ext_add_o;
   logic                       trans_alloc_req_o;
   logic [NB_TRANSFERS-1:0]    trans_alloc_clr_o;
   logic                       busy_o;

   logic [NB_TRANSFERS-1:0]    hold_mask = '0;   // Done bit kept low while a transfer runs
   logic [NB_TRANSFERS-1:0]    done_mask = '0;
   logic [SID_WIDTH-1:0]       sid;
   logic [SID_WIDTH-1:0]       dummy_sid;

   task automatic stop_with_failure(input string why);
      $display("%s", why);
      $display(">>> FAIL");
      $fatal(1, "simulation stopped");
   endtask

   `include "tb_dma_ctrl_model.svh"

   dma_ctrl_top #(
      .NB_TRANSFERS   (NB_TRANSFERS),
      .TCDM_ADD_WIDTH (TCDM_ADD_WIDTH),
      .EXT_ADD_WIDTH  (EXT_ADD_WIDTH),
      .PE_ID_WIDTH    (PE_ID_WIDTH)
   ) dma_ctrl_top_inst (.*);

   always #20 clk_i = ~clk_i;   // 40 ns period

   // ******************************
   // Downstream responders
   // ******************************
   always @(posedge clk_i)
   begin
      cmd_gnt_i            <= 1'($urandom);
      tcdm_gnt_i           <= 1'($urandom);
      ext_gnt_i            <= 1'($urandom);
      trans_alloc_gnt_i    <= 1'($urandom);
      trans_alloc_ret_i    <= SID_WIDTH'($urandom);
      trans_alloc_status_i <= NB_TRANSFERS'($urandom);
      trans_status_i       <= (NB_TRANSFERS'($urandom) & ~hold_mask) | done_mask;
   end

   always @(negedge clk_i)
      model_cycle();   // Outputs are stable mid-cycle

   initial
   begin
      repeat (N_OPS * 200) @(posedge clk_i);
      stop_with_failure("timeout while waiting for the DUT to finish the test sequence");
   end

   // Presents one target request, max_wait of zero waits for the grant
   task automatic access(input logic rd, input logic [1:0] off, input logic [31:0] wdata,
                         input int max_wait, output logic [SID_WIDTH-1:0] sid_seen);
      int waited;
      waited = 0;
      @(posedge clk_i);
      ctrl_targ_req_i  <= 1'b1;
      ctrl_targ_type_i <= rd;
      ctrl_targ_add_i  <= {28'($urandom), off, 2'($urandom)};
      ctrl_targ_data_i <= wdata;
      ctrl_targ_id_i   <= PE_ID_WIDTH'($urandom);
      do
      begin
         @(negedge clk_i);
         waited++;
      end
      while (!ctrl_targ_gnt_o && waited != max_wait);
      sid_seen = trans_alloc_ret_i;
      @(posedge clk_i);
      ctrl_targ_req_i <= 1'b0;
   endtask

   task automatic idle_gap();
      repeat ($urandom_range(0, 3)) @(posedge clk_i);
   endtask

   task automatic arb_handshake(input logic [SID_WIDTH-1:0] hs_sid);
      @(posedge clk_i);
      arb_req_i <= 1'b1;
      arb_gnt_i <= 1'b1;
      arb_sid_i <= hs_sid;
      @(posedge clk_i);
      arb_req_i <= 1'b0;
      arb_gnt_i <= 1'b0;
   endtask

   // Three beats, then the barrier and the done bit of the stored SID
   task automatic run_command(input logic [SID_WIDTH-1:0] cmd_sid);
      logic [SID_WIDTH-1:0] unused;
      @(negedge clk_i);
      hold_mask = NB_TRANSFERS'(1) << cmd_sid;
      access(1'b0, 2'd0, $urandom(), 0, unused);
      idle_gap();
      access(1'b0, 2'd0, $urandom(), 0, unused);
      idle_gap();
      access(1'b0, 2'd0, $urandom(), 0, unused);
      // Done bit already high, only the barrier keeps the engine busy
      @(negedge clk_i);
      hold_mask = '0;
      done_mask = NB_TRANSFERS'(1) << cmd_sid;
      idle_gap();
      arb_handshake(SID_WIDTH'(cmd_sid + 1'b1));   // Foreign SID first
      idle_gap();
      @(negedge clk_i);
      done_mask = '0;
      hold_mask = NB_TRANSFERS'(1) << cmd_sid;
      arb_handshake(cmd_sid);
      idle_gap();
      @(negedge clk_i);
      hold_mask = '0;
      done_mask = NB_TRANSFERS'(1) << cmd_sid;
      do
      begin
         @(negedge clk_i);
      end
      while (busy_o);
      done_mask = '0;
   endtask

   // ******************************
   // Main sequence
   // ******************************
   initial
   begin
      void'($urandom(SEED));
      repeat (2) @(posedge clk_i);
      rst_ni <= 1'b1;
      for (int round = 0; round < N_ROUNDS; round++)
      begin
         access(1'b1, 2'd0, '0, 0, sid);           // SID read
         idle_gap();
         access(1'b1, 2'd1, '0, 0, dummy_sid);     // Status read
         idle_gap();
         access(1'b0, 2'd1, $urandom(), 0, dummy_sid);
         idle_gap();
         run_command(sid);
         idle_gap();
         // Status read in the middle of a command must abort it
         access(1'b0, 2'd0, $urandom(), 0, dummy_sid);
         access(1'b1, 2'd1, '0, 1, dummy_sid);
         @(negedge clk_i);
         check_bit("busy_o", busy_o, 1'b0);
      end
      repeat (2) @(posedge clk_i);
      $display(">>> PASS");
      $finish;
   end

endmodule

// File: project.f
+incdir+.
dma_ctrl_pkg.sv
ctrl_op_if.sv
ctrl_resp_if.sv
ctrl_decode.sv
cmd_sequencer.sv
ctrl_response.sv
dma_ctrl_top.sv
tb_dma_ctrl.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the DMA control port testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   -f project.f --top-module tb_dma_ctrl -o tb_dma_ctrl_sim \
   && ./obj_dir/tb_dma_ctrl_sim | tee /dev/stderr | grep -x -F ">>> PASS" > /dev/null \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
